//--- vlog.f
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/regAddrSelect.sv
src/bankedRegDecode.sv
src/readPortHazard.sv
src/writeAddrPipe.sv
src/exceptionVector.sv
src/addressPath.sv
sim/tbClock.sv
sim/addressPathTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the address path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module addressPathTb \
  -f vlog.f \
  -o addressPathSim

simOutput=$(./obj_dir/addressPathSim)
echo "$simOutput"

if grep -qx "Test completed successfully" <<< "$simOutput"; then
  exit 0
fi
exit 1

//--- sim/addressPathTb.sv
`timescale 1ns/10ps
`include "archConsts.svh"

module addressPathTb
  import isaPkg::*;
  import pipePkg::*;
();

  localparam int          resetCycles = 5;
  localparam int          cleanCycles = 200;
  localparam int          stallCycles = 800;
  localparam int          totalCycles = resetCycles + cleanCycles + stallCycles + 2;
  localparam int          watchdogNs  = (totalCycles + 100) * 8;
  localparam int unsigned randomSeed  = 32'hb8821e64;

  logic        clk;
  logic        rstN;
  instrT       instrD;
  instrT       instrE;
  decodeCtrlT  decodeCtrl;
  cpsrLowT     cpsr;
  logic        swiE;
  logic        writeMultLoE;
  excFlagsT    excFlagsW;
  stageCtlT    stageCtl;
  physSelT     ra1D;
  physSelT     ra2D;
  physSelT     wa3W;
  hazardMatchT hazardMatch;
  addrT        vectorPcNextF;
  logic        exceptionSelectW;

  // Reference model state, mirrors the pipeline registers
  physSelT     modelRaE [`READ_PORTS];
  physSelT     modelWa3ERaw;
  physSelT     modelWa3M;
  physSelT     modelWa3W;
  logic        resetSeen = 1'b0;

  // Expected values for the current cycle
  logic [4:0]  decodeMode;
  physSelT     expRa [`READ_PORTS];
  physSelT     expWa3D;
  physSelT     expWa3E;
  hazardMatchT expMatch;

  int          errorCount = 0;
  int          checkCount = 0;

  tbClock #(
    .periodNs    (8),
    .resetCycles (resetCycles)
  ) uClock (
    .clk  (clk),
    .rstN (rstN)
  );

  addressPath dut_i (
    .clk              (clk),
    .rstN             (rstN),
    .instrD           (instrD),
    .decodeCtrl       (decodeCtrl),
    .cpsr             (cpsr),
    .swiE             (swiE),
    .instrE           (instrE),
    .writeMultLoE     (writeMultLoE),
    .excFlagsW        (excFlagsW),
    .stageCtl         (stageCtl),
    .ra1D             (ra1D),
    .ra2D             (ra2D),
    .wa3W             (wa3W),
    .hazardMatch      (hazardMatch),
    .vectorPcNextF    (vectorPcNextF),
    .exceptionSelectW (exceptionSelectW)
  );

  // ======================================================================
  // Reference rules
  // ======================================================================
  // SWI forces svc, unknown encodings act as user
  function automatic logic [4:0] lookupMode(cpsrLowT c, logic swi);
    if (swi) begin
      return 5'b10011;
    end
    case (c[4:0])
      5'b10000, 5'b10001, 5'b10010, 5'b10011,
      5'b10111, 5'b11011, 5'b11111: return c[4:0];
      default: return 5'b10000;
    endcase
  endfunction

  // Bank table: fiq R8-R14 at 16, irq/svc/abt/und R13-R14 at 23/25/27/29
  function automatic physSelT expectSel(logic [3:0] r, logic [4:0] mode);
    int idx;
    idx = int'(r);
    case (mode)
      5'b10001: if (idx >= 8 && idx <= 14) idx = idx + 8;
      5'b10010: if (idx == 13 || idx == 14) idx = idx + 10;
      5'b10011: if (idx == 13 || idx == 14) idx = idx + 12;
      5'b10111: if (idx == 13 || idx == 14) idx = idx + 14;
      5'b11011: if (idx == 13 || idx == 14) idx = idx + 16;
      default: ;
    endcase
    return physSelT'(1) << idx;
  endfunction

  function automatic logic [3:0] ra1Field(instrT i, decodeCtrlT c);
    case (c.ra1Sel)
      ra1Rn:   return i[19:16];
      ra1Pc:   return 4'd15;
      ra1Rs:   return i[11:8];
      default: return i[3:0];
    endcase
  endfunction

  function automatic logic [3:0] ra2Field(instrT i, decodeCtrlT c);
    case (c.ra2Sel)
      ra2Rd:   return i[15:12];
      ra2Rs:   return i[11:8];
      default: return i[3:0];
    endcase
  endfunction

  function automatic logic [3:0] destField(instrT i, decodeCtrlT c);
    return (c.destSel == destRn) ? i[19:16] : i[15:12];
  endfunction

  // Priority reset, dabt, fiq, irq, pabt, und, swi
  function automatic addrT expectVector(excFlagsT f);
    if (f.reset) return 32'h00;
    if (f.dataAbort) return 32'h10;
    if (f.fiq) return 32'h1C;
    if (f.irq) return 32'h18;
    if (f.prefetchAbort) return 32'h0C;
    if (f.undef) return 32'h04;
    if (f.swi) return 32'h08;
    return 32'h00;
  endfunction

  always_comb begin
    decodeMode = lookupMode(cpsr, swiE);
    expRa[0]   = expectSel(ra1Field(instrD, decodeCtrl), decodeMode);
    expRa[1]   = expectSel(ra2Field(instrD, decodeCtrl), decodeMode);
    expWa3D    = expectSel(destField(instrD, decodeCtrl), decodeMode);
    // RdLo uses the CPSR mode, no SWI override
    if (writeMultLoE) begin
      expWa3E = expectSel(instrE[15:12], lookupMode(cpsr, 1'b0));
    end else begin
      expWa3E = modelWa3ERaw;
    end
    for (int p = 0; p < `READ_PORTS; p++) begin
      expMatch[p].matchM  = (modelRaE[p] == modelWa3M) && (modelRaE[p] != '0);
      expMatch[p].matchW  = (modelRaE[p] == modelWa3W) && (modelRaE[p] != '0);
      expMatch[p].matchDE = (expRa[p] == expWa3E) && (expRa[p] != '0);
    end
  end

  // Shadow pipeline, flush before stall in writeback
  always @(posedge clk) begin
    if (!rstN) begin
      resetSeen <= 1'b1;
      for (int p = 0; p < `READ_PORTS; p++) begin
        modelRaE[p] <= '0;
      end
      modelWa3ERaw <= '0;
      modelWa3M    <= '0;
      modelWa3W    <= '0;
    end else begin
      if (!stageCtl.stallE) begin
        for (int p = 0; p < `READ_PORTS; p++) begin
          modelRaE[p] <= expRa[p];
        end
        modelWa3ERaw <= expWa3D;
      end
      if (!stageCtl.stallM) begin
        modelWa3M <= expWa3E;
      end
      if (stageCtl.flushW) begin
        modelWa3W <= '0;
      end else if (!stageCtl.stallW) begin
        modelWa3W <= modelWa3M;
      end
    end
  end

  // ======================================================================
  // Checks, sampled mid-cycle
  // ======================================================================
  task automatic logMismatch(string what, logic [31:0] got, logic [31:0] want);
    errorCount++;
    $display("Error at %0t ns: %s got %h expected %h", $time, what, got, want);
  endtask

  always @(negedge clk) begin
    if (resetSeen) begin
      checkCount++;
      assert (ra1D == expRa[0])
        else logMismatch("ra1D", ra1D, expRa[0]);
      assert (ra2D == expRa[1])
        else logMismatch("ra2D", ra2D, expRa[1]);
      assert (wa3W == modelWa3W)
        else logMismatch("wa3W", wa3W, modelWa3W);
      for (int p = 0; p < `READ_PORTS; p++) begin
        assert (hazardMatch[p] == expMatch[p])
          else logMismatch($sformatf("hazardMatch[%0d]", p),
                           32'(hazardMatch[p]), 32'(expMatch[p]));
      end
      assert (vectorPcNextF == expectVector(excFlagsW))
        else logMismatch("vectorPcNextF", vectorPcNextF, expectVector(excFlagsW));
      assert (exceptionSelectW == (excFlagsW != '0))
        else logMismatch("exceptionSelectW", 32'(exceptionSelectW), 32'(excFlagsW != '0));
      // Everything cleared while in reset
      if (!rstN) begin
        assert (wa3W == '0 && hazardMatch == '0)
          else logMismatch("reset state", wa3W, 32'h0);
      end
    end
  end

  // ======================================================================
  // Stimulus
  // ======================================================================
  task automatic initInputs();
    instrD       = '0;
    instrE       = '0;
    decodeCtrl   = '0;
    cpsr         = 12'h010;
    swiE         = 1'b0;
    writeMultLoE = 1'b0;
    excFlagsW    = '0;
    stageCtl     = '0;
  endtask

  task automatic driveRandom(bit allowStalls);
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  m;
    r  = $urandom();
    r2 = $urandom();
    instrD                = $urandom();
    instrE                = $urandom();
    decodeCtrl.ra1Sel     = ra1SelT'(r[1:0]);
    decodeCtrl.ra2Sel     = ra2SelT'(2'($urandom_range(2, 0)));
    decodeCtrl.destSel    = destSelT'(r[4]);
    // Mostly legal modes, sometimes a junk encoding
    case (r[7:5])
      3'd0: m = 5'b10000;
      3'd1: m = 5'b10001;
      3'd2: m = 5'b10010;
      3'd3: m = 5'b10011;
      3'd4: m = 5'b10111;
      3'd5: m = 5'b11011;
      3'd6: m = 5'b11111;
      default: m = r[12:8];
    endcase
    cpsr                  = {r[19:13], m};
    swiE                  = (r[21:20] == 2'b00);
    writeMultLoE          = (r[23:22] == 2'b00);
    stageCtl.stallE       = allowStalls && (r[25:24] == 2'b00);
    stageCtl.stallM       = allowStalls && (r[27:26] == 2'b00);
    stageCtl.stallW       = allowStalls && (r[29:28] == 2'b00);
    stageCtl.flushW       = allowStalls && (r2[16:14] == 3'b000);
    // None, single flag or any mix
    if (r2[1:0] == 2'b00) begin
      excFlagsW = '0;
    end else if (r2[10:9] == 2'b00) begin
      excFlagsW = excFlagsT'(7'b1 << $urandom_range(6, 0));
    end else begin
      excFlagsW = excFlagsT'(r2[8:2]);
    end
  endtask

  initial begin
    int unsigned seedSink;
    seedSink = $urandom(randomSeed);
    initInputs();
    @(posedge rstN);
    // Free-flowing pipe first, then stalls and flushes
    repeat (cleanCycles) begin
      @(posedge clk);
      #1 driveRandom(1'b0);
    end
    repeat (stallCycles) begin
      @(posedge clk);
      #1 driveRandom(1'b1);
    end
    @(negedge clk);
    #1;
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdogNs);
    $display("Watchdog expired before the stimulus finished");
    $display("Test failed");
    $finish;
  end

endmodule

//--- sim/tbClock.sv
`timescale 1ns/10ps

module tbClock #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 5
) (
  output logic clk,
  output logic rstN
);

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Reset released just after an edge, away from sampling
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

//--- src/addressPath.sv
`timescale 1ns/10ps
`include "archConsts.svh"

module addressPath
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic        clk,
  input  logic        rstN,
  // From controller
  input  instrT       instrD,
  input  decodeCtrlT  decodeCtrl,
  input  cpsrLowT     cpsr,
  input  logic        swiE,
  input  instrT       instrE,
  input  logic        writeMultLoE,
  input  excFlagsT    excFlagsW,
  // From hazard unit
  input  stageCtlT    stageCtl,
  // To register file
  output physSelT     ra1D,
  output physSelT     ra2D,
  output physSelT     wa3W,
  // To hazard unit
  output hazardMatchT hazardMatch,
  // To fetch
  output addrT        vectorPcNextF,
  output logic        exceptionSelectW
);

  archRegT                   ra1Arch;
  archRegT                   ra2Arch;
  archRegT                   destArch;
  physSelT [`READ_PORTS-1:0] readSel;
  physSelT                   wa3D;
  physSelT                   wa3E;
  physSelT                   wa3M;

  // ======================================================================
  // Decode
  // ======================================================================
  regAddrSelect uSelect (
    .instrD   (instrD),
    .ctrl     (decodeCtrl),
    .ra1Arch  (ra1Arch),
    .ra2Arch  (ra2Arch),
    .destArch (destArch)
  );

  bankedRegDecode uBanked (
    .ra1Arch  (ra1Arch),
    .ra2Arch  (ra2Arch),
    .destArch (destArch),
    .cpsr     (cpsr),
    .swiE     (swiE),
    .readSel  (readSel),
    .wa3D     (wa3D)
  );

  assign ra1D = readSel[0];
  assign ra2D = readSel[1];

  // ======================================================================
  // Execute through writeback
  // ======================================================================
  writeAddrPipe uWritePipe (
    .clk          (clk),
    .rstN         (rstN),
    .stage        (stageCtl),
    .wa3D         (wa3D),
    .instrE       (instrE),
    .cpsr         (cpsr),
    .writeMultLoE (writeMultLoE),
    .wa3E         (wa3E),
    .wa3M         (wa3M),
    .wa3W         (wa3W)
  );

  // One checker per read port
  for (genvar p = 0; p < `READ_PORTS; p++) begin : gPort
    readPortHazard uHazard (
      .clk    (clk),
      .rstN   (rstN),
      .stallE (stageCtl.stallE),
      .raD    (readSel[p]),
      .wa3E   (wa3E),
      .wa3M   (wa3M),
      .wa3W   (wa3W),
      .match  (hazardMatch[p])
    );
  end

  // Exception redirect, sits near fetch
  exceptionVector uVector (
    .excFlagsW        (excFlagsW),
    .vectorPcNextF    (vectorPcNextF),
    .exceptionSelectW (exceptionSelectW)
  );

endmodule

//--- src/exceptionVector.sv
`timescale 1ns/10ps
`include "archConsts.svh"

module exceptionVector
  import isaPkg::*;
(
  input  excFlagsT excFlagsW,
  output addrT     vectorPcNextF,
  output logic     exceptionSelectW
);

  // Any pending exception redirects fetch
  assign exceptionSelectW = |excFlagsW;

  // ARM priority: reset, dabt, fiq, irq, pabt, und, swi
  always_comb begin
    if (excFlagsW.reset) begin
      vectorPcNextF = `VEC_BASE + `VEC_RESET;
    end else if (excFlagsW.dataAbort) begin
      vectorPcNextF = `VEC_BASE + `VEC_DATA_ABORT;
    end else if (excFlagsW.fiq) begin
      vectorPcNextF = `VEC_BASE + `VEC_FIQ;
    end else if (excFlagsW.irq) begin
      vectorPcNextF = `VEC_BASE + `VEC_IRQ;
    end else if (excFlagsW.prefetchAbort) begin
      vectorPcNextF = `VEC_BASE + `VEC_PREFETCH_ABORT;
    end else if (excFlagsW.undef) begin
      vectorPcNextF = `VEC_BASE + `VEC_UNDEF;
    end else if (excFlagsW.swi) begin
      vectorPcNextF = `VEC_BASE + `VEC_SWI;
    end else begin
      // Nothing pending
      vectorPcNextF = '0;
    end
  end

endmodule

//--- src/writeAddrPipe.sv
`timescale 1ns/10ps

module writeAddrPipe
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  stageCtlT stage,
  input  physSelT  wa3D,
  input  instrT    instrE,
  input  cpsrLowT  cpsr,
  input  logic     writeMultLoE,
  output physSelT  wa3E,
  output physSelT  wa3M,
  output physSelT  wa3W
);

  physSelT wa3ERaw;
  physSelT rdLoE;

  // ======================================================================
  // Execute
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wa3ERaw <= '0;
    end else if (!stage.stallE) begin
      wa3ERaw <= wa3D;
    end
  end

  // RdLo of long multiply, bits 15:12 of instrE
  // Banked with current CPSR mode
  assign rdLoE = physRegOf(instrE[15:12], modeOf(cpsr));

  // Second write of long multiply takes over
  assign wa3E = writeMultLoE ? rdLoE : wa3ERaw;

  // ======================================================================
  // Memory
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wa3M <= '0;
    end else if (!stage.stallM) begin
      wa3M <= wa3E;
    end
  end

  // ======================================================================
  // Writeback
  // ======================================================================
  // Flush beats stall
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wa3W <= '0;
    end else if (stage.flushW) begin
      wa3W <= '0;
    end else if (!stage.stallW) begin
      wa3W <= wa3M;
    end
  end

endmodule

//--- src/readPortHazard.sv
`timescale 1ns/10ps

module readPortHazard
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  logic      stallE,
  input  physSelT   raD,
  input  physSelT   wa3E,
  input  physSelT   wa3M,
  input  physSelT   wa3W,
  output portMatchT match
);

  physSelT raE;

  // Execute copy of read select
  always_ff @(posedge clk) begin
    if (!rstN) begin
      raE <= '0;
    end else if (!stallE) begin
      raE <= raD;
    end
  end

  // Forwarding matches from memory and writeback
  // Zero select means no register, never a match
  assign match.matchM = (raE == wa3M) && (raE != '0);
  assign match.matchW = (raE == wa3W) && (raE != '0);

  // Load-use check, decode read vs execute write
  assign match.matchDE = (raD == wa3E) && (raD != '0);

endmodule

//--- src/bankedRegDecode.sv
`timescale 1ns/10ps
`include "archConsts.svh"

module bankedRegDecode
  import isaPkg::*;
(
  input  archRegT                     ra1Arch,
  input  archRegT                     ra2Arch,
  input  archRegT                     destArch,
  input  cpsrLowT                     cpsr,
  input  logic                        swiE,
  output physSelT [`READ_PORTS-1:0]   readSel,
  output physSelT                     wa3D
);

  modeT effMode;

  // ======================================================================
  // Effective mode for decode lookups
  // ======================================================================
  // SWI in execute has not yet switched CPSR
  // so decode must already see svc bank
  always_comb begin
    if (swiE) begin
      effMode = modeSvc;
    end else begin
      // Illegal encodings fall back to user
      effMode = modeOf(cpsr);
    end
  end

  // ======================================================================
  // Banked lookups
  // ======================================================================
  // Read ports
  always_comb begin
    readSel[0] = physRegOf(ra1Arch, effMode);
    readSel[1] = physRegOf(ra2Arch, effMode);
  end

  // Write port, carried down the pipe
  assign wa3D = physRegOf(destArch, effMode);

endmodule

//--- src/regAddrSelect.sv
`timescale 1ns/10ps
`include "archConsts.svh"

module regAddrSelect
  import isaPkg::*;
  import pipePkg::*;
(
  input  instrT      instrD,
  input  decodeCtrlT ctrl,
  output archRegT    ra1Arch,
  output archRegT    ra2Arch,
  output archRegT    destArch
);

  // Read port 1
  always_comb begin
    case (ctrl.ra1Sel)
      ra1Rn:    ra1Arch = instrD[19:16];
      // PC is always R15
      ra1Pc:    ra1Arch = archRegT'(`ARCH_REGS - 1);
      // Register-shifted register operand
      ra1Rs:    ra1Arch = instrD[11:8];
      ra1MulRm: ra1Arch = instrD[3:0];
      default:  ra1Arch = instrD[19:16];
    endcase
  end

  // Read port 2
  always_comb begin
    case (ctrl.ra2Sel)
      ra2Rm:   ra2Arch = instrD[3:0];
      // Store data comes from Rd
      ra2Rd:   ra2Arch = instrD[15:12];
      ra2Rs:   ra2Arch = instrD[11:8];
      default: ra2Arch = instrD[3:0];
    endcase
  end

  // Multiplies write the Rn field as destination
  always_comb begin
    case (ctrl.destSel)
      destRd:  destArch = instrD[15:12];
      destRn:  destArch = instrD[19:16];
      default: destArch = instrD[15:12];
    endcase
  end

endmodule

//--- src/pipePkg.sv
`include "archConsts.svh"

package pipePkg;

  // ======================================================================
  // Decode control from main controller
  // ======================================================================
  // RA1 source: Rn, PC, Rs or multiply Rm
  typedef enum logic [1:0] {
    ra1Rn,
    ra1Pc,
    ra1Rs,
    ra1MulRm
  } ra1SelT;

  // RA2 source: Rm, Rd (stores) or Rs
  typedef enum logic [1:0] {
    ra2Rm,
    ra2Rd,
    ra2Rs
  } ra2SelT;

  // Destination: Rd, or Rn for multiply
  typedef enum logic {
    destRd,
    destRn
  } destSelT;

  typedef struct packed {
    ra1SelT  ra1Sel;
    ra2SelT  ra2Sel;
    destSelT destSel;
  } decodeCtrlT;

  // ======================================================================
  // Hazard unit interface
  // ======================================================================
  typedef struct packed {
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushW;
  } stageCtlT;

  // Per read port: E vs M, E vs W, D vs E
  typedef struct packed {
    logic matchM;
    logic matchW;
    logic matchDE;
  } portMatchT;

  typedef portMatchT [`READ_PORTS-1:0] hazardMatchT;

endpackage

//--- src/isaPkg.sv
`include "archConsts.svh"

package isaPkg;

  // Plain widths with an architectural meaning
  typedef logic [$clog2(`ARCH_REGS)-1:0] archRegT;
  typedef logic [`PHYS_REGS-1:0]         physSelT;
  typedef logic [31:0]                   instrT;
  typedef logic [31:0]                   addrT;
  typedef logic [11:0]                   cpsrLowT;

  // ARM mode field encodings in CPSR bits 4:0
  typedef enum logic [4:0] {
    modeUser = 5'b10000,
    modeFiq  = 5'b10001,
    modeIrq  = 5'b10010,
    modeSvc  = 5'b10011,
    modeAbt  = 5'b10111,
    modeUnd  = 5'b11011,
    modeSys  = 5'b11111
  } modeT;

  // Pending exceptions seen in writeback
  typedef struct packed {
    logic reset;
    logic undef;
    logic swi;
    logic prefetchAbort;
    logic dataAbort;
    logic irq;
    logic fiq;
  } excFlagsT;

  // Mode from CPSR; anything not a legal mode acts as user
  function automatic modeT modeOf(cpsrLowT cpsr);
    case (cpsr[4:0])
      modeFiq, modeIrq, modeSvc, modeAbt, modeUnd, modeSys: modeOf = modeT'(cpsr[4:0]);
      default: modeOf = modeUser;
    endcase
  endfunction

  // Architectural number to one-hot physical select
  function automatic physSelT physRegOf(archRegT arch, modeT mode);
    int unsigned first;
    int unsigned base;
    int unsigned idx;
    // First banked register and where its bank starts
    case (mode)
      modeFiq: begin
        first = 8;
        base  = 16;
      end
      modeIrq: begin
        first = 13;
        base  = 23;
      end
      modeSvc: begin
        first = 13;
        base  = 25;
      end
      modeAbt: begin
        first = 13;
        base  = 27;
      end
      modeUnd: begin
        first = 13;
        base  = 29;
      end
      default: begin
        // User and sys share the base set
        first = `ARCH_REGS;
        base  = 0;
      end
    endcase
    idx = 32'(arch);
    // R15 never banked
    if (idx >= first && idx != `ARCH_REGS - 1) begin
      idx = base + idx - first;
    end
    physRegOf = physSelT'(1) << idx;
  endfunction

endpackage

//--- src/archConsts.svh
`ifndef ARCH_CONSTS_SVH
`define ARCH_CONSTS_SVH

// Register counts
`define ARCH_REGS  16
`define PHYS_REGS  32
`define READ_PORTS 2

// ======================================================================
// Exception vector table
// ======================================================================
`define VEC_BASE           32'h0000_0000
`define VEC_RESET          32'h0000_0000
`define VEC_UNDEF          32'h0000_0004
`define VEC_SWI            32'h0000_0008
`define VEC_PREFETCH_ABORT 32'h0000_000C
`define VEC_DATA_ABORT     32'h0000_0010
`define VEC_IRQ            32'h0000_0018
`define VEC_FIQ            32'h0000_001C

`endif
